//--- design/raster_pkg.sv
package raster_pkg;

    // memory bus types
    typedef logic [31:0] word_t;
    typedef logic [25:0] addr_t;

    // screen space
    typedef logic signed [15:0] coord_t;
    typedef logic signed [33:0] area_t;

    // triangle record layout in memory
    localparam int record_words = 15;
    localparam int vertex_words = 5;
    localparam int word_bytes   = 4;

    // word index inside a record
    typedef logic [$clog2(record_words)-1:0] count_t;

    typedef enum logic {
        send_idle,
        send_active
    } send_state_t;

    typedef enum logic {
        recv_idle,
        recv_active
    } recv_state_t;

endpackage

//--- design/triangle_if.sv
`timescale 1ns/10ps

interface triangle_if
    import raster_pkg::*;
();

    logic  valid;
    // per vertex fields, index 0..2
    word_t x        [3];
    word_t y        [3];
    word_t z        [3];
    word_t color    [3];
    word_t texcoord [3];

    modport source (
        output valid, x, y, z, color, texcoord
    );

    modport sink (
        input valid, x, y, z, color, texcoord
    );

endinterface

//--- design/vertex_fetch.sv
`timescale 1ns/10ps

module vertex_fetch
    import raster_pkg::*;
(
    input  logic  clock,
    input  logic  reset,

    input  logic  fetch_enable,
    input  addr_t addr_in,
    output logic  fetch_busy,

    output addr_t master_address,
    output logic  master_read,
    input  logic  master_waitrequest,
    input  word_t master_readdata,
    input  logic  master_readdatavalid,

    triangle_if.source tri_out
);

    send_state_t send_state;
    count_t      send_count;
    logic        start;
    logic        accepted;
    logic        last_accept;

    recv_state_t recv_state;
    count_t      recv_count;
    logic        last_word;
    word_t       record_buf  [record_words-1];
    word_t       record_full [record_words];

    // request side
    assign start       = (send_state == send_idle) && fetch_enable;
    assign accepted    = master_read && !master_waitrequest;
    assign last_accept = accepted && (send_count == count_t'(record_words - 1));

    assign fetch_busy  = (send_state == send_active);
    assign master_read = (send_state == send_active);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            send_state <= send_idle;
            send_count <= '0;
        end else begin
            case (send_state)
                send_idle: begin
                    if (fetch_enable) begin
                        send_state <= send_active;
                        send_count <= '0;
                    end
                end
                send_active: begin
                    if (last_accept) begin
                        send_state <= send_idle;
                        send_count <= '0;
                    end else if (accepted) begin
                        send_count <= send_count + 1'b1;
                    end
                end
                default: begin
                    send_state <= send_idle;
                end
            endcase
        end
    end

    // address moves only when the current read is taken
    always_ff @(posedge clock) begin
        if (start) begin
            master_address <= addr_in;
        end else if (accepted && !last_accept) begin
            master_address <= master_address + addr_t'(word_bytes);
        end
    end

    // receive side
    assign last_word = master_readdatavalid &&
                       (recv_count == count_t'(record_words - 1));

    always_comb begin
        for (int i = 0; i < record_words - 1; i++) begin
            record_full[i] = record_buf[i];
        end
        // final word goes straight from the bus
        record_full[record_words-1] = master_readdata;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            recv_state    <= recv_idle;
            recv_count    <= '0;
            tri_out.valid <= 1'b0;
        end else begin
            tri_out.valid <= 1'b0;
            case (recv_state)
                recv_idle: begin
                    if (master_readdatavalid) begin
                        recv_state <= recv_active;
                        recv_count <= 4'd1;
                    end
                end
                recv_active: begin
                    if (last_word) begin
                        recv_state    <= recv_idle;
                        recv_count    <= '0;
                        tri_out.valid <= 1'b1;
                    end else if (master_readdatavalid) begin
                        recv_count <= recv_count + 1'b1;
                    end
                end
                default: begin
                    recv_state <= recv_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (master_readdatavalid && !last_word) begin
            record_buf[recv_count] <= master_readdata;
        end
    end

    // unpack by vertex, fields in x y z color texcoord order
    always_ff @(posedge clock) begin
        if (last_word) begin
            for (int v = 0; v < 3; v++) begin
                tri_out.x[v]        <= record_full[v * vertex_words];
                tri_out.y[v]        <= record_full[v * vertex_words + 1];
                tri_out.z[v]        <= record_full[v * vertex_words + 2];
                tri_out.color[v]    <= record_full[v * vertex_words + 3];
                tri_out.texcoord[v] <= record_full[v * vertex_words + 4];
            end
        end
    end

endmodule

//--- design/triangle_setup.sv
`timescale 1ns/10ps

module triangle_setup
    import raster_pkg::*;
(
    input  logic   clock,
    input  logic   reset,

    triangle_if.sink tri_in,

    output logic   tri_valid,
    output coord_t min_x,
    output coord_t max_x,
    output coord_t min_y,
    output coord_t max_y,
    output area_t  area,
    output logic   culled
);

    coord_t vx [3];
    coord_t vy [3];

    // stage one
    logic              s1_valid;
    coord_t            s1_min_x;
    coord_t            s1_max_x;
    coord_t            s1_min_y;
    coord_t            s1_max_y;
    logic signed [16:0] s1_dx10;
    logic signed [16:0] s1_dy20;
    logic signed [16:0] s1_dx20;
    logic signed [16:0] s1_dy10;

    // stage two
    area_t prod_a;
    area_t prod_b;
    area_t area_next;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // coordinates sit in the low half of each word
    always_comb begin
        for (int v = 0; v < 3; v++) begin
            vx[v] = tri_in.x[v][15:0];
            vy[v] = tri_in.y[v][15:0];
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= tri_in.valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_min_x <= min3(vx[0], vx[1], vx[2]);
        s1_max_x <= max3(vx[0], vx[1], vx[2]);
        s1_min_y <= min3(vy[0], vy[1], vy[2]);
        s1_max_y <= max3(vy[0], vy[1], vy[2]);
        // one extra bit so differences never wrap
        s1_dx10  <= 17'(vx[1]) - 17'(vx[0]);
        s1_dy20  <= 17'(vy[2]) - 17'(vy[0]);
        s1_dx20  <= 17'(vx[2]) - 17'(vx[0]);
        s1_dy10  <= 17'(vy[1]) - 17'(vy[0]);
    end

    // doubled area, positive for counter-clockwise
    assign prod_a    = area_t'(s1_dx10) * area_t'(s1_dy20);
    assign prod_b    = area_t'(s1_dx20) * area_t'(s1_dy10);
    assign area_next = prod_a - prod_b;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            tri_valid <= 1'b0;
        end else begin
            tri_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        min_x  <= s1_min_x;
        max_x  <= s1_max_x;
        min_y  <= s1_min_y;
        max_y  <= s1_max_y;
        area   <= area_next;
        // degenerate or back facing
        culled <= (area_next <= 0);
    end

endmodule

//--- design/rasterizer_front.sv
`timescale 1ns/10ps

module rasterizer_front
    import raster_pkg::*;
(
    input  logic   clock,
    input  logic   reset,

    input  logic   fetch_enable,
    input  addr_t  addr_in,
    output logic   fetch_busy,

    output addr_t  master_address,
    output logic   master_read,
    input  logic   master_waitrequest,
    input  word_t  master_readdata,
    input  logic   master_readdatavalid,

    output logic   tri_valid,
    output coord_t min_x,
    output coord_t max_x,
    output coord_t min_y,
    output coord_t max_y,
    output area_t  area,
    output logic   culled
);

    triangle_if tri_bus ();

    vertex_fetch vertex_fetch_inst (
        .clock                (clock),
        .reset                (reset),
        .fetch_enable         (fetch_enable),
        .addr_in              (addr_in),
        .fetch_busy           (fetch_busy),
        .master_address       (master_address),
        .master_read          (master_read),
        .master_waitrequest   (master_waitrequest),
        .master_readdata      (master_readdata),
        .master_readdatavalid (master_readdatavalid),
        .tri_out              (tri_bus.source)
    );

    triangle_setup triangle_setup_inst (
        .clock     (clock),
        .reset     (reset),
        .tri_in    (tri_bus.sink),
        .tri_valid (tri_valid),
        .min_x     (min_x),
        .max_x     (max_x),
        .min_y     (min_y),
        .max_y     (max_y),
        .area      (area),
        .culled    (culled)
    );

endmodule

//--- dv/rasterizer_front_checker.sv
`timescale 1ns/10ps

module rasterizer_front_checker
    import raster_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   fetch_enable,
    input  addr_t  addr_in,
    input  logic   fetch_busy,
    input  addr_t  master_address,
    input  logic   master_read,
    input  logic   master_waitrequest,
    input  word_t  master_readdata,
    input  logic   master_readdatavalid,
    input  logic   tri_valid,
    input  coord_t min_x,
    input  coord_t max_x,
    input  coord_t min_y,
    input  coord_t max_y,
    input  area_t  area,
    input  logic   culled,
    output int     error_count,
    output int     tri_count,
    output int     pending
);

    addr_t  exp_addr [$];
    word_t  rec      [$];
    coord_t e_min_x  [$];
    coord_t e_max_x  [$];
    coord_t e_min_y  [$];
    coord_t e_max_y  [$];
    longint e_area   [$];
    logic   e_culled [$];
    longint e_due    [$];
    longint cycle;
    int     accepted_enables;

    assign pending = accepted_enables - tri_count;

    task automatic compare(input string name, input longint exp, input longint act);
        if (exp != act) begin
            error_count++;
            $display("Error at %0t: %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    // reference model of the setup math, from the fetched words
    task automatic build_expected();
        longint vx [3];
        longint vy [3];
        longint a;
        for (int v = 0; v < 3; v++) begin
            vx[v] = coord_t'(rec[v * vertex_words][15:0]);
            vy[v] = coord_t'(rec[v * vertex_words + 1][15:0]);
        end
        a = (vx[1] - vx[0]) * (vy[2] - vy[0]) - (vx[2] - vx[0]) * (vy[1] - vy[0]);
        e_min_x.push_back(coord_t'((vx[0] < vx[1]) ? ((vx[0] < vx[2]) ? vx[0] : vx[2])
                                                   : ((vx[1] < vx[2]) ? vx[1] : vx[2])));
        e_max_x.push_back(coord_t'((vx[0] > vx[1]) ? ((vx[0] > vx[2]) ? vx[0] : vx[2])
                                                   : ((vx[1] > vx[2]) ? vx[1] : vx[2])));
        e_min_y.push_back(coord_t'((vy[0] < vy[1]) ? ((vy[0] < vy[2]) ? vy[0] : vy[2])
                                                   : ((vy[1] < vy[2]) ? vy[1] : vy[2])));
        e_max_y.push_back(coord_t'((vy[0] > vy[1]) ? ((vy[0] > vy[2]) ? vy[0] : vy[2])
                                                   : ((vy[1] > vy[2]) ? vy[1] : vy[2])));
        e_area.push_back(a);
        e_culled.push_back(a <= 0);
        e_due.push_back(cycle + 3);
        rec.delete();
    endtask

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            cycle = 0;
            accepted_enables = 0;
            exp_addr.delete();
            rec.delete();
        end else begin
            cycle++;
            if (fetch_enable && !fetch_busy) begin
                accepted_enables++;
                for (int k = 0; k < record_words; k++) begin
                    exp_addr.push_back(addr_in + addr_t'(word_bytes * k));
                end
            end
            if (master_read && !master_waitrequest) begin
                if (exp_addr.size() == 0) begin
                    error_count++;
                    $display("read accepted at %0t with no fetch pending", $time);
                end else begin
                    compare("master_address", exp_addr.pop_front(), master_address);
                end
            end
            if (master_readdatavalid) begin
                rec.push_back(master_readdata);
                if (rec.size() == record_words) begin
                    build_expected();
                end
            end
            if (tri_valid) begin
                tri_count++;
                if (e_due.size() == 0) begin
                    error_count++;
                    $display("tri_valid at %0t with no triangle expected", $time);
                end else begin
                    compare("tri_valid cycle", e_due.pop_front(), cycle);
                    compare("min_x", e_min_x.pop_front(), min_x);
                    compare("max_x", e_max_x.pop_front(), max_x);
                    compare("min_y", e_min_y.pop_front(), min_y);
                    compare("max_y", e_max_y.pop_front(), max_y);
                    compare("area", e_area.pop_front(), area);
                    compare("culled", e_culled.pop_front(), culled);
                end
            end
        end
    end

    initial begin
        error_count = 0;
        tri_count = 0;
    end

endmodule

//--- dv/vertex_fetch_assert.sv
`timescale 1ns/10ps

module vertex_fetch_assert
    import raster_pkg::*;
(
    input logic  clock,
    input logic  reset,
    input logic  fetch_busy,
    input addr_t master_address,
    input logic  master_read,
    input logic  master_waitrequest,
    input logic  valid
);

    // stalled request stays put
    held_request: assert property (@(posedge clock) disable iff (!reset)
        (master_read && master_waitrequest) |=> (master_read && $stable(master_address)))
        else $error("read request changed while waitrequest was high");

    valid_pulse: assert property (@(posedge clock) disable iff (!reset)
        valid |=> !valid)
        else $error("triangle valid high for two cycles");

    read_when_busy: assert property (@(posedge clock) disable iff (!reset)
        !fetch_busy |-> !master_read)
        else $error("master_read high while fetch_busy low");

endmodule

bind vertex_fetch vertex_fetch_assert vertex_fetch_assert_inst (
    .clock              (clock),
    .reset              (reset),
    .fetch_busy         (fetch_busy),
    .master_address     (master_address),
    .master_read        (master_read),
    .master_waitrequest (master_waitrequest),
    .valid              (tri_out.valid)
);

//--- dv/rasterizer_front_tb.sv
`timescale 1ns/10ps

module rasterizer_front_tb
    import raster_pkg::*;
();

    localparam int mem_words = 1024;
    localparam int timeout   = 2000;

    logic   clock, reset, fetch_enable, fetch_busy;
    addr_t  addr_in, master_address;
    logic   master_read, master_waitrequest, master_readdatavalid;
    word_t  master_readdata;
    logic   tri_valid, culled;
    coord_t min_x, max_x, min_y, max_y;
    area_t  area;
    int     checker_errors, tri_count, pending;

    word_t  mem [mem_words];
    word_t  resp_data [$];
    longint resp_due  [$];
    longint cycle, last_due;
    int     latency;
    int     seed = 32'h0e4dc073;
    bit     stall_en;
    int     tb_errors, tests, mark;

    rasterizer_front rasterizer_front_inst (.*);

    rasterizer_front_checker checker_inst (.*, .error_count(checker_errors));

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // memory slave with random stalls and 1 to 4 cycles of latency
    always @(posedge clock) begin
        cycle++;
        if (master_read && !master_waitrequest) begin
            latency  = {$random(seed)} % 4;
            last_due = (cycle + latency > last_due) ? cycle + latency : last_due + 1;
            resp_data.push_back(mem[master_address[11:2]]);
            resp_due.push_back(last_due);
        end
        if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
            void'(resp_due.pop_front());
            master_readdata      <= resp_data.pop_front();
            master_readdatavalid <= 1'b1;
        end else begin
            master_readdatavalid <= 1'b0;
        end
        master_waitrequest <= stall_en && ({$random(seed)} % 3 == 0);
    end

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Errors found");
        $finish;
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            tb_errors++;
            $display("Error at %0t: %s expected 0 actual %b", $time, name, value);
        end
    endtask

    // holds the enable until the fetch block is idle and takes it
    task automatic issue_fetch(input int word_index);
        int n;
        fetch_enable <= 1'b1;
        addr_in      <= addr_t'(word_index * word_bytes);
        n = 0;
        do begin
            @(posedge clock);
            if (++n > timeout) fail_timeout("fetch_busy to fall");
        end while (fetch_busy);
        fetch_enable <= 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do begin
            @(posedge clock);
            if (++n > timeout) fail_timeout("triangle results");
        end while (pending != 0 || fetch_busy);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("%s: %0d errors", name, tb_errors + checker_errors - mark);
        mark = tb_errors + checker_errors;
    endtask

    function automatic int random_record();
        return {$random(seed)} % (mem_words - record_words);
    endfunction

    task automatic put_vertex(input int base, input int v, input int x, input int y);
        mem[base + v * vertex_words]     = word_t'(x);
        mem[base + v * vertex_words + 1] = word_t'(y);
    endtask

    initial begin
        int n, expect_tris;
        reset = 1'b0;
        fetch_enable = 1'b0;
        addr_in = '0;
        master_waitrequest = 1'b0;
        master_readdata = '0;
        master_readdatavalid = 1'b0;
        stall_en = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = $random(seed);
        end
        // clockwise, degenerate, counter-clockwise
        put_vertex(0, 0, 0, 0);
        put_vertex(0, 1, 0, 10);
        put_vertex(0, 2, 10, 0);
        put_vertex(15, 0, 1, 1);
        put_vertex(15, 1, 2, 2);
        put_vertex(15, 2, 3, 3);
        put_vertex(30, 0, -5, -5);
        put_vertex(30, 1, 20, -5);
        put_vertex(30, 2, -5, 30);
        repeat (10) @(posedge clock);
        reset <= 1'b1;

        repeat (5) begin
            @(posedge clock);
            expect_low("master_read", master_read);
            expect_low("fetch_busy", fetch_busy);
            expect_low("tri_valid", tri_valid);
        end
        finish_test("reset");

        issue_fetch(random_record());
        n = 0;
        @(posedge clock);
        while (fetch_busy) begin
            n++;
            @(posedge clock);
            if (n > timeout) fail_timeout("end of single fetch");
        end
        if (n != record_words) begin
            tb_errors++;
            $display("Error at %0t: fetch_busy cycles expected 15 actual %0d", $time, n);
        end
        wait_done();
        finish_test("single fetch");

        stall_en = 1'b1;
        repeat (6) begin
            issue_fetch(random_record());
            wait_done();
        end
        finish_test("random stalls");

        repeat (4) issue_fetch(random_record());
        wait_done();
        finish_test("back to back");

        issue_fetch(0);
        issue_fetch(15);
        issue_fetch(30);
        wait_done();
        finish_test("culling");

        stall_en = 1'b0;
        expect_tris = tri_count + 1;
        issue_fetch(random_record());
        repeat (5) begin
            fetch_enable <= 1'b1;
            addr_in      <= addr_t'(random_record() * word_bytes);
            @(posedge clock);
        end
        fetch_enable <= 1'b0;
        wait_done();
        if (tri_count != expect_tris) begin
            tb_errors++;
            $display("Error at %0t: triangle count expected %0d actual %0d", $time,
                     expect_tris, tri_count);
        end
        finish_test("enable while busy");

        $display("%0d tests, %0d triangles, %0d errors", tests, tri_count,
                 tb_errors + checker_errors);
        if (tb_errors + checker_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- files.f
design/raster_pkg.sv
design/triangle_if.sv
design/vertex_fetch.sv
design/triangle_setup.sv
design/rasterizer_front.sv
dv/rasterizer_front_checker.sv
dv/vertex_fetch_assert.sv
dv/rasterizer_front_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rasterizer_front_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
